// ==== hw/mine_pkg.sv ====
package mine_pkg;

	localparam int MAX_BOARD_X = 20;               // Widest board
	localparam int MAX_BOARD_Y = 13;               // Tallest board
	localparam int X_BITS      = 5;
	localparam int Y_BITS      = 4;
	localparam int ADDR_BITS   = X_BITS + Y_BITS;  // Cell address is {x, y}
	localparam int CLEAR_LAST  = 319;              // Top address of both RAMs
	localparam int COUNT_BITS  = 9;                // Cell and mine counts
	localparam int CLOCK_HZ    = 50000000;         // Cycles per second by default
	localparam int TIMER_BITS  = 12;
	localparam int LFSR_TAP_HI = 8;                // x^9 + x^5 + 1
	localparam int LFSR_TAP_LO = 4;

	typedef enum logic [2:0] {
		CMD_UP,
		CMD_DOWN,
		CMD_LEFT,
		CMD_RIGHT,
		CMD_REVEAL,
		CMD_FLAG,
		CMD_NEW_GAME
	} cmd_t;

	typedef enum logic [1:0] {
		ST_SETUP,
		ST_PLAY,
		ST_WON,
		ST_LOST
	} status_t;

	// Codes 1 to 8 hold the neighbour mine count of a revealed cell
	typedef enum logic [3:0] {
		TILE_HIDDEN = 4'd0,
		TILE_1      = 4'd1,
		TILE_2      = 4'd2,
		TILE_3      = 4'd3,
		TILE_4      = 4'd4,
		TILE_5      = 4'd5,
		TILE_6      = 4'd6,
		TILE_7      = 4'd7,
		TILE_8      = 4'd8,
		TILE_EMPTY  = 4'd9,
		TILE_FLAG   = 4'd10
	} tile_t;

	typedef enum logic [2:0] {
		WALK_IDLE,
		WALK_UP,
		WALK_DOWN,
		WALK_LEFT,
		WALK_RIGHT,
		WALK_CLEAR,
		WALK_NB_STEP,
		WALK_NB_RESTART
	} walk_op_t;

	typedef enum logic [3:0] {
		S_IDLE,
		S_CLEAR,
		S_SETTLE,
		S_REVEAL,
		S_FLAG,
		S_PLACE,
		S_COUNT,
		S_WRITE
	} state_t;

endpackage

// ==== hw/game_config.sv ====
`timescale 1ns/1ps

module game_config
	import mine_pkg::*;
(
	input  logic                  clock,
	input  logic                  resetn,
	input  logic                  cfg_write,
	input  logic [X_BITS-1:0]     cfg_board_x,
	input  logic [Y_BITS-1:0]     cfg_board_y,
	input  logic [COUNT_BITS-1:0] cfg_mines,
	input  logic [ADDR_BITS-1:0]  cfg_seed,
	input  logic                  busy,
	output logic                  cfg_accept,
	output logic [X_BITS-1:0]     board_x,
	output logic [Y_BITS-1:0]     board_y,
	output logic [COUNT_BITS-1:0] mine_count,
	output logic [ADDR_BITS-1:0]  seed
);

	logic [COUNT_BITS-1:0] cfg_cells;  // Requested width times height
	logic                  size_ok;
	logic                  mines_ok;

	assign cfg_cells = COUNT_BITS'(cfg_board_x) * COUNT_BITS'(cfg_board_y);
	assign size_ok   = (cfg_board_x != '0) && (cfg_board_x <= X_BITS'(MAX_BOARD_X))
		&& (cfg_board_y != '0) && (cfg_board_y <= Y_BITS'(MAX_BOARD_Y));
	assign mines_ok  = cfg_mines < (cfg_cells - 1'b1);  // Leaves room for the first reveal

	// Zero seed would lock the LFSR
	assign cfg_accept = cfg_write && !busy && size_ok && mines_ok && (cfg_seed != '0);

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			board_x    <= '0;
			board_y    <= '0;
			mine_count <= '0;
			seed       <= '0;
		end
		else if (cfg_accept)
		begin
			board_x    <= cfg_board_x;
			board_y    <= cfg_board_y;
			mine_count <= cfg_mines;
			seed       <= cfg_seed;
		end
	end

endmodule

// ==== hw/game_control.sv ====
`timescale 1ns/1ps

module game_control
	import mine_pkg::*;
(
	input  logic       clock,
	input  logic       resetn,
	input  logic       cmd_valid,
	input  cmd_t       cmd_op,
	input  logic       cfg_accept,
	input  logic       place_done,
	input  logic       count_done,
	input  logic       clear_done,
	input  logic       cursor_is_mine,
	input  logic       all_safe_revealed,
	input  logic [3:0] neighbour_mines,
	input  tile_t      cursor_tile,
	output walk_op_t   walker_op,
	output logic       place_start,
	output logic       count_start,
	output logic       clear,
	output logic       tile_write,
	output tile_t      tile_code,
	output logic       timer_run,
	output status_t    status,
	output logic       busy
);

	state_t state;
	state_t state_next;
	logic   first_done;  // Mines are placed once per game
	logic   lose;

	assign busy      = state != S_IDLE;
	assign timer_run = first_done && (status == ST_PLAY);

	always_comb
	begin
		state_next  = state;
		walker_op   = WALK_IDLE;
		place_start = 1'b0;
		count_start = 1'b0;
		clear       = 1'b0;
		tile_write  = 1'b0;
		tile_code   = TILE_HIDDEN;
		lose        = 1'b0;
		case (state)
			S_IDLE:
			begin
				if (cfg_accept)
					state_next = S_CLEAR;  // New configuration wins over commands
				else if (cmd_valid && status == ST_PLAY)
				begin
					case (cmd_op)
						CMD_UP:       walker_op = WALK_UP;
						CMD_DOWN:     walker_op = WALK_DOWN;
						CMD_LEFT:     walker_op = WALK_LEFT;
						CMD_RIGHT:    walker_op = WALK_RIGHT;
						CMD_REVEAL:   state_next = S_REVEAL;
						CMD_FLAG:     state_next = S_FLAG;
						CMD_NEW_GAME: state_next = S_CLEAR;
						default:      state_next = S_IDLE;
					endcase
				end
				else if (cmd_valid && status != ST_SETUP && cmd_op == CMD_NEW_GAME)
					state_next = S_CLEAR;  // Only way out of won or lost
			end
			S_CLEAR:
			begin
				walker_op = WALK_CLEAR;
				clear     = 1'b1;
				if (clear_done)
					state_next = S_SETTLE;
			end
			S_SETTLE: state_next = S_IDLE;  // Tile read catches up with the cursor
			S_REVEAL:
			begin
				if (cursor_tile != TILE_HIDDEN)
					state_next = S_IDLE;  // Flagged or already open
				else if (!first_done)
				begin
					place_start = 1'b1;
					state_next  = S_PLACE;
				end
				else if (cursor_is_mine)
				begin
					lose       = 1'b1;
					state_next = S_IDLE;
				end
				else
				begin
					count_start = 1'b1;
					walker_op   = WALK_NB_RESTART;
					state_next  = S_COUNT;
				end
			end
			S_PLACE:
			begin
				if (place_done)
				begin
					count_start = 1'b1;  // First cell is never a mine
					walker_op   = WALK_NB_RESTART;
					state_next  = S_COUNT;
				end
			end
			S_COUNT:
			begin
				walker_op = WALK_NB_STEP;  // One neighbour per cycle
				if (count_done)
					state_next = S_WRITE;
			end
			S_WRITE:
			begin
				tile_write = 1'b1;
				tile_code  = (neighbour_mines == 4'd0) ? TILE_EMPTY : tile_t'(neighbour_mines);
				state_next = S_SETTLE;
			end
			S_FLAG:
			begin
				state_next = S_IDLE;
				if (first_done && cursor_tile == TILE_HIDDEN)
				begin
					tile_write = 1'b1;
					tile_code  = TILE_FLAG;
					state_next = S_SETTLE;
				end
				else if (first_done && cursor_tile == TILE_FLAG)
				begin
					tile_write = 1'b1;
					tile_code  = TILE_HIDDEN;
					state_next = S_SETTLE;
				end
			end
			default: state_next = S_IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			state      <= S_IDLE;
			status     <= ST_SETUP;
			first_done <= 1'b0;
		end
		else
		begin
			state <= state_next;
			if (clear)
				first_done <= 1'b0;
			else if (place_start)
				first_done <= 1'b1;  // Timer starts here
			if (clear && clear_done)
				status <= ST_PLAY;
			else if (lose)
				status <= ST_LOST;
			else if (state == S_SETTLE && status == ST_PLAY && all_safe_revealed)
				status <= ST_WON;
		end
	end

endmodule

// ==== hw/board_walker.sv ====
`timescale 1ns/1ps

module board_walker
	import mine_pkg::*;
(
	input  logic                 clock,
	input  logic                 resetn,
	input  walk_op_t             walker_op,
	input  logic [X_BITS-1:0]    board_x,
	input  logic [Y_BITS-1:0]    board_y,
	output logic [ADDR_BITS-1:0] cell_addr,
	output logic [X_BITS-1:0]    cursor_x,
	output logic [Y_BITS-1:0]    cursor_y,
	output logic                 neighbour_valid,
	output logic                 clear_done
);

	logic [ADDR_BITS-1:0] clear_addr;
	logic [2:0]           nb_idx;     // Which of the eight neighbours
	logic [3:0]           nb_offset;  // {dx, dy}, each biased by one
	logic [X_BITS-1:0]    nb_x;
	logic [Y_BITS-1:0]    nb_y;

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			cursor_x <= '0;
			cursor_y <= '0;
		end
		else
		begin
			case (walker_op)
				WALK_UP:    cursor_y <= (cursor_y == '0) ? board_y - 1'b1 : cursor_y - 1'b1;
				WALK_DOWN:  cursor_y <= (cursor_y >= board_y - 1'b1) ? '0 : cursor_y + 1'b1;
				WALK_LEFT:  cursor_x <= (cursor_x == '0) ? board_x - 1'b1 : cursor_x - 1'b1;
				WALK_RIGHT: cursor_x <= (cursor_x >= board_x - 1'b1) ? '0 : cursor_x + 1'b1;
				WALK_CLEAR:
				begin
					cursor_x <= '0;  // New game starts at the corner
					cursor_y <= '0;
				end
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock)
	begin
		if (!resetn)
			clear_addr <= '0;
		else if (walker_op == WALK_CLEAR)
			clear_addr <= clear_done ? '0 : clear_addr + 1'b1;  // Walks 0 to 319
	end

	assign clear_done = clear_addr == ADDR_BITS'(CLEAR_LAST);

	always_ff @(posedge clock)
	begin
		if (!resetn)
			nb_idx <= '0;
		else if (walker_op == WALK_NB_RESTART)
			nb_idx <= '0;
		else if (walker_op == WALK_NB_STEP)
			nb_idx <= nb_idx + 1'b1;
	end

	always_comb
	begin
		case (nb_idx)
			3'd0:    nb_offset = 4'b0000;  // Up left
			3'd1:    nb_offset = 4'b0001;
			3'd2:    nb_offset = 4'b0010;
			3'd3:    nb_offset = 4'b0100;  // Same column
			3'd4:    nb_offset = 4'b0110;
			3'd5:    nb_offset = 4'b1000;
			3'd6:    nb_offset = 4'b1001;
			default: nb_offset = 4'b1010;  // Down right
		endcase
	end

	// Minus one at the left or top edge wraps high and fails the range check
	assign nb_x            = cursor_x + X_BITS'(nb_offset[3:2]) - 1'b1;
	assign nb_y            = cursor_y + Y_BITS'(nb_offset[1:0]) - 1'b1;
	assign neighbour_valid = (nb_x < board_x) && (nb_y < board_y);

	always_comb
	begin
		case (walker_op)
			WALK_CLEAR:   cell_addr = clear_addr;
			WALK_NB_STEP: cell_addr = {nb_x, nb_y};
			default:      cell_addr = {cursor_x, cursor_y};
		endcase
	end

endmodule

// ==== hw/mine_field.sv ====
`timescale 1ns/1ps

module mine_field
	import mine_pkg::*;
(
	input  logic                  clock,
	input  logic                  resetn,
	input  logic                  clear,
	input  logic [ADDR_BITS-1:0]  cell_addr,
	input  logic                  neighbour_valid,
	input  logic                  place_start,
	input  logic                  count_start,
	input  logic [X_BITS-1:0]     board_x,
	input  logic [Y_BITS-1:0]     board_y,
	input  logic [COUNT_BITS-1:0] mine_count,
	input  logic [ADDR_BITS-1:0]  seed,
	output logic                  place_done,
	output logic                  count_done,
	output logic [3:0]            neighbour_mines,
	output logic                  cursor_is_mine
);

	logic                  mine_ram [0:CLEAR_LAST];  // One bit per cell
	logic [ADDR_BITS-1:0]  lfsr;
	logic [ADDR_BITS-1:0]  lfsr_next;                // Candidate cell
	logic [COUNT_BITS-1:0] placed;
	logic                  placing;
	logic                  place_step;
	logic                  cand_ok;
	logic                  counting;
	logic [2:0]            count_idx;

	assign lfsr_next  = {lfsr[ADDR_BITS-2:0], lfsr[LFSR_TAP_HI] ^ lfsr[LFSR_TAP_LO]};
	assign place_step = placing && (placed != mine_count);

	// Off board, already a mine, or the first revealed cell
	assign cand_ok = (lfsr_next[ADDR_BITS-1:Y_BITS] < board_x)
		&& (lfsr_next[Y_BITS-1:0] < board_y)
		&& !mine_ram[lfsr_next]
		&& (lfsr_next != cell_addr);

	assign cursor_is_mine = mine_ram[cell_addr];

	always_ff @(posedge clock)
	begin
		if (clear)
			mine_ram[cell_addr] <= 1'b0;  // Address comes from the clear walk
		else if (place_step && cand_ok)
			mine_ram[lfsr_next] <= 1'b1;
	end

	always_ff @(posedge clock)
	begin
		if (clear)
			lfsr <= seed;  // Same seed gives the same board
		else if (place_step)
			lfsr <= lfsr_next;
	end

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			placing    <= 1'b0;
			placed     <= '0;
			place_done <= 1'b0;
		end
		else
		begin
			place_done <= 1'b0;
			if (place_start)
			begin
				placing <= 1'b1;
				placed  <= '0;
			end
			else if (placing && placed == mine_count)
			begin
				placing    <= 1'b0;
				place_done <= 1'b1;
			end
			else if (place_step && cand_ok)
				placed <= placed + 1'b1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (!resetn)
		begin
			counting        <= 1'b0;
			count_idx       <= '0;
			count_done      <= 1'b0;
			neighbour_mines <= '0;
		end
		else
		begin
			count_done <= 1'b0;
			if (count_start)
			begin
				counting        <= 1'b1;
				count_idx       <= '0;
				neighbour_mines <= '0;
			end
			else if (counting)
			begin
				if (neighbour_valid && mine_ram[cell_addr])
					neighbour_mines <= neighbour_mines + 1'b1;
				count_idx <= count_idx + 1'b1;
				if (count_idx == 3'd7)
				begin
					counting   <= 1'b0;  // Eight neighbours seen
					count_done <= 1'b1;
				end
			end
		end
	end

endmodule

// ==== hw/tile_store.sv ====
`timescale 1ns/1ps

module tile_store
	import mine_pkg::*;
(
	input  logic                  clock,
	input  logic                  resetn,
	input  logic                  clear,
	input  logic                  tile_write,
	input  tile_t                 tile_code,
	input  logic [ADDR_BITS-1:0]  cell_addr,
	input  logic [X_BITS-1:0]     board_x,
	input  logic [Y_BITS-1:0]     board_y,
	input  logic [COUNT_BITS-1:0] mine_count,
	output tile_t                 cursor_tile,
	output logic                  all_safe_revealed
);

	tile_t                 tile_ram [0:CLEAR_LAST];
	logic [COUNT_BITS-1:0] revealed;    // Opened safe cells
	logic [COUNT_BITS-1:0] safe_cells;
	logic                  opens_cell;

	// Registered read, one cycle behind the address
	always_ff @(posedge clock)
	begin
		if (clear)
			tile_ram[cell_addr] <= TILE_HIDDEN;
		else if (tile_write)
			tile_ram[cell_addr] <= tile_code;
		cursor_tile <= tile_ram[cell_addr];
	end

	// Flag writes leave the count alone
	assign opens_cell = tile_write && (tile_code != TILE_HIDDEN) && (tile_code != TILE_FLAG);

	always_ff @(posedge clock)
	begin
		if (!resetn || clear)
			revealed <= '0;
		else if (opens_cell)
			revealed <= revealed + 1'b1;
	end

	assign safe_cells        = COUNT_BITS'(board_x) * COUNT_BITS'(board_y) - mine_count;
	assign all_safe_revealed = revealed == safe_cells;

endmodule

// ==== hw/game_timer.sv ====
`timescale 1ns/1ps

module game_timer
	import mine_pkg::*;
#(
	parameter int tick_cycles = CLOCK_HZ
)
(
	input  logic                  clock,
	input  logic                  resetn,
	input  logic                  run,
	input  logic                  clear,
	output logic [TIMER_BITS-1:0] timer
);

	localparam int DIV_BITS = $clog2(tick_cycles + 1);

	logic [DIV_BITS-1:0] div_cnt;  // Cycles into the current second
	logic                tick;

	assign tick = div_cnt == DIV_BITS'(tick_cycles - 1);

	always_ff @(posedge clock)
	begin
		if (!resetn || clear)
		begin
			div_cnt <= '0;
			timer   <= '0;
		end
		else if (run)
		begin
			if (tick)
			begin
				div_cnt <= '0;
				timer   <= timer + 1'b1;  // Wraps after 4095 s
			end
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

// ==== hw/minesweeper_top.sv ====
`timescale 1ns/1ps

module minesweeper_top
	import mine_pkg::*;
#(
	parameter int tick_cycles = CLOCK_HZ
)
(
	input  logic                  clock,
	input  logic                  resetn,
	input  logic                  cfg_write,
	input  logic [X_BITS-1:0]     cfg_board_x,
	input  logic [Y_BITS-1:0]     cfg_board_y,
	input  logic [COUNT_BITS-1:0] cfg_mines,
	input  logic [ADDR_BITS-1:0]  cfg_seed,
	input  logic                  cmd_valid,
	input  cmd_t                  cmd_op,
	output status_t               status,
	output logic                  busy,
	output logic [X_BITS-1:0]     cursor_x,
	output logic [Y_BITS-1:0]     cursor_y,
	output tile_t                 cursor_tile,
	output logic [TIMER_BITS-1:0] timer
);

	logic                  cfg_accept;
	logic [X_BITS-1:0]     board_x;
	logic [Y_BITS-1:0]     board_y;
	logic [COUNT_BITS-1:0] mine_count;
	logic [ADDR_BITS-1:0]  seed;
	walk_op_t              walker_op;
	logic [ADDR_BITS-1:0]  cell_addr;     // Cursor, neighbour or clear address
	logic                  neighbour_valid;
	logic                  clear_done;
	logic                  place_start;
	logic                  place_done;
	logic                  count_start;
	logic                  count_done;
	logic [3:0]            neighbour_mines;
	logic                  cursor_is_mine;
	logic                  clear;         // New game in progress
	logic                  tile_write;
	tile_t                 tile_code;
	logic                  all_safe_revealed;
	logic                  timer_run;

	game_config game_config_i (
		.clock(clock), .resetn(resetn), .cfg_write(cfg_write),
		.cfg_board_x(cfg_board_x), .cfg_board_y(cfg_board_y),
		.cfg_mines(cfg_mines), .cfg_seed(cfg_seed), .busy(busy),
		.cfg_accept(cfg_accept), .board_x(board_x), .board_y(board_y),
		.mine_count(mine_count), .seed(seed)
	);

	game_control game_control_i (
		.clock(clock), .resetn(resetn), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
		.cfg_accept(cfg_accept), .place_done(place_done), .count_done(count_done),
		.clear_done(clear_done), .cursor_is_mine(cursor_is_mine),
		.all_safe_revealed(all_safe_revealed), .neighbour_mines(neighbour_mines),
		.cursor_tile(cursor_tile), .walker_op(walker_op), .place_start(place_start),
		.count_start(count_start), .clear(clear), .tile_write(tile_write),
		.tile_code(tile_code), .timer_run(timer_run), .status(status), .busy(busy)
	);

	board_walker board_walker_i (
		.clock(clock), .resetn(resetn), .walker_op(walker_op),
		.board_x(board_x), .board_y(board_y), .cell_addr(cell_addr),
		.cursor_x(cursor_x), .cursor_y(cursor_y),
		.neighbour_valid(neighbour_valid), .clear_done(clear_done)
	);

	mine_field mine_field_i (
		.clock(clock), .resetn(resetn), .clear(clear), .cell_addr(cell_addr),
		.neighbour_valid(neighbour_valid), .place_start(place_start),
		.count_start(count_start), .board_x(board_x), .board_y(board_y),
		.mine_count(mine_count), .seed(seed), .place_done(place_done),
		.count_done(count_done), .neighbour_mines(neighbour_mines),
		.cursor_is_mine(cursor_is_mine)
	);

	tile_store tile_store_i (
		.clock(clock), .resetn(resetn), .clear(clear), .tile_write(tile_write),
		.tile_code(tile_code), .cell_addr(cell_addr), .board_x(board_x),
		.board_y(board_y), .mine_count(mine_count), .cursor_tile(cursor_tile),
		.all_safe_revealed(all_safe_revealed)
	);

	game_timer #(
		.tick_cycles(tick_cycles)
	) game_timer_i (
		.clock(clock), .resetn(resetn), .run(timer_run), .clear(clear), .timer(timer)
	);

endmodule

// ==== verif/minesweeper_tb.sv ====
`timescale 1ns/1ps

module minesweeper_tb
	import mine_pkg::*;
();

	localparam int BOARD_W    = 6;
	localparam int BOARD_H    = 5;
	localparam int MINES      = 6;
	localparam int SEED       = 9'h1B3;
	localparam int WAIT_LIMIT = 2000;  // Longest busy phase in cycles

	logic                  clock;
	logic                  resetn;
	logic                  cfg_write;
	logic [X_BITS-1:0]     cfg_board_x;
	logic [Y_BITS-1:0]     cfg_board_y;
	logic [COUNT_BITS-1:0] cfg_mines;
	logic [ADDR_BITS-1:0]  cfg_seed;
	logic                  cmd_valid;
	cmd_t                  cmd_op;
	status_t               status;
	logic                  busy;
	logic [X_BITS-1:0]     cursor_x;
	logic [Y_BITS-1:0]     cursor_y;
	tile_t                 cursor_tile;
	logic [TIMER_BITS-1:0] timer;

	int      errors;
	int      checks;
	int      cur_x;       // Model cursor
	int      cur_y;
	bit      first_done;  // Model has placed its mines
	int      revealed;
	status_t exp_status;
	bit      mine [0:MAX_BOARD_X-1][0:MAX_BOARD_Y-1];
	tile_t   exp_tile [0:MAX_BOARD_X-1][0:MAX_BOARD_Y-1];

	minesweeper_top #(
		.tick_cycles(50)
	) dut_i (
		.clock(clock), .resetn(resetn), .cfg_write(cfg_write),
		.cfg_board_x(cfg_board_x), .cfg_board_y(cfg_board_y), .cfg_mines(cfg_mines),
		.cfg_seed(cfg_seed), .cmd_valid(cmd_valid), .cmd_op(cmd_op), .status(status),
		.busy(busy), .cursor_x(cursor_x), .cursor_y(cursor_y),
		.cursor_tile(cursor_tile), .timer(timer)
	);

	always #4 clock = ~clock;  // 125 MHz

	task automatic expect_equal(input string name, input int got, input int expected);
	begin
		checks++;
		if (got != expected)
		begin
			errors++;
			$display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, expected);
		end
	end
	endtask

	task automatic finish_run();
	begin
		$display("Errors: %0d in %0d checks", errors, checks);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end
	endtask

	// Returns at the first falling edge with busy low
	task automatic wait_not_busy();
		int n;
	begin
		n = 0;
		@(negedge clock);
		while (busy && n < WAIT_LIMIT)
		begin
			@(negedge clock);
			n++;
		end
		if (busy)
		begin
			errors++;
			$display("Timeout: busy stayed high for %0d cycles", WAIT_LIMIT);
			finish_run();
		end
	end
	endtask

	task automatic pulse_cmd(input cmd_t op);
	begin
		@(posedge clock);
		cmd_valid <= 1'b1;
		cmd_op    <= op;
		@(posedge clock);
		cmd_valid <= 1'b0;  // DUT has taken it on this edge
	end
	endtask

	task automatic reset_model();
	begin
		for (int x = 0; x < MAX_BOARD_X; x++)
			for (int y = 0; y < MAX_BOARD_Y; y++)
			begin
				mine[x][y]     = 1'b0;
				exp_tile[x][y] = TILE_HIDDEN;
			end
		cur_x      = 0;
		cur_y      = 0;
		first_done = 1'b0;
		revealed   = 0;
		exp_status = ST_PLAY;
	end
	endtask

	// LFSR x^9+x^5+1 from the seed, skipping off-board, repeated and first cells
	task automatic place_mines(input int fx, input int fy);
		logic [8:0] lfsr;
		int         placed;
		int         x;
		int         y;
	begin
		lfsr   = SEED[8:0];
		placed = 0;
		while (placed < MINES)
		begin
			lfsr = {lfsr[7:0], lfsr[8] ^ lfsr[4]};
			x    = int'(lfsr[8:4]);  // Upper bits are the column
			y    = int'(lfsr[3:0]);
			if (x < BOARD_W && y < BOARD_H && !(x == fx && y == fy) && !mine[x][y])
			begin
				mine[x][y] = 1'b1;
				placed++;
			end
		end
	end
	endtask

	function automatic int count_near(input int x, input int y);
		int n;
		int nx;
		int ny;
		n = 0;
		for (int dx = -1; dx <= 1; dx++)
			for (int dy = -1; dy <= 1; dy++)
			begin
				nx = x + dx;
				ny = y + dy;
				if ((dx != 0 || dy != 0) && nx >= 0 && nx < BOARD_W && ny >= 0
					&& ny < BOARD_H && mine[nx][ny])
					n++;  // Off-board cells never count
			end
		return n;
	endfunction

	task automatic check_cursor();
	begin
		expect_equal("status", status, exp_status);
		expect_equal("cursor_x", cursor_x, cur_x);
		expect_equal("cursor_y", cursor_y, cur_y);
		expect_equal("cursor_tile", cursor_tile, exp_tile[cur_x][cur_y]);
	end
	endtask

	task automatic move(input cmd_t op);
	begin
		pulse_cmd(op);
		if (exp_status == ST_PLAY)
		begin
			case (op)
				CMD_UP:    cur_y = (cur_y == 0) ? BOARD_H - 1 : cur_y - 1;
				CMD_DOWN:  cur_y = (cur_y == BOARD_H - 1) ? 0 : cur_y + 1;
				CMD_LEFT:  cur_x = (cur_x == 0) ? BOARD_W - 1 : cur_x - 1;
				CMD_RIGHT: cur_x = (cur_x == BOARD_W - 1) ? 0 : cur_x + 1;
				default: ;
			endcase
		end
		@(posedge clock);  // Tile read trails the cursor
		@(negedge clock);
		check_cursor();
	end
	endtask

	task automatic goto_cell(input int x, input int y);
	begin
		while (cur_x < x)
			move(CMD_RIGHT);
		while (cur_x > x)
			move(CMD_LEFT);
		while (cur_y < y)
			move(CMD_DOWN);
		while (cur_y > y)
			move(CMD_UP);
	end
	endtask

	task automatic reveal_at(input int x, input int y);
		int n;
	begin
		goto_cell(x, y);
		pulse_cmd(CMD_REVEAL);
		wait_not_busy();
		if (exp_status == ST_PLAY && exp_tile[x][y] == TILE_HIDDEN)
		begin
			if (!first_done)
			begin
				place_mines(x, y);
				first_done = 1'b1;
			end
			if (mine[x][y])
				exp_status = ST_LOST;
			else
			begin
				n              = count_near(x, y);
				exp_tile[x][y] = (n == 0) ? TILE_EMPTY : tile_t'(n);
				revealed++;
				if (revealed == BOARD_W * BOARD_H - MINES)
					exp_status = ST_WON;
			end
		end
		check_cursor();
	end
	endtask

	task automatic flag_here();
	begin
		pulse_cmd(CMD_FLAG);
		wait_not_busy();
		if (exp_status == ST_PLAY && first_done)
		begin
			if (exp_tile[cur_x][cur_y] == TILE_HIDDEN)
				exp_tile[cur_x][cur_y] = TILE_FLAG;
			else if (exp_tile[cur_x][cur_y] == TILE_FLAG)
				exp_tile[cur_x][cur_y] = TILE_HIDDEN;
		end
		check_cursor();
	end
	endtask

	task automatic check_all_hidden();
	begin
		check_cursor();
		for (int y = 0; y < BOARD_H; y++)
			for (int x = 0; x < BOARD_W; x++)
				goto_cell(x, y);  // Every move checks the tile it lands on
	end
	endtask

	task automatic configure(input int w, input int h, input int m, input int s, input bit ok);
	begin
		@(posedge clock);
		cfg_write   <= 1'b1;
		cfg_board_x <= X_BITS'(w);
		cfg_board_y <= Y_BITS'(h);
		cfg_mines   <= COUNT_BITS'(m);
		cfg_seed    <= ADDR_BITS'(s);
		@(posedge clock);
		cfg_write <= 1'b0;
		wait_not_busy();
		if (ok)
			reset_model();
		expect_equal("status", status, exp_status);
		expect_equal("timer", timer, 0);
	end
	endtask

	task automatic test_reset_config();
	begin
		expect_equal("status", status, ST_SETUP);
		expect_equal("busy", busy, 0);
		expect_equal("timer", timer, 0);
		expect_equal("cursor_x", cursor_x, 0);
		expect_equal("cursor_y", cursor_y, 0);
		configure(21, BOARD_H, MINES, SEED, 1'b0);                    // Too wide
		configure(BOARD_W, 14, MINES, SEED, 1'b0);                    // Too tall
		configure(BOARD_W, BOARD_H, BOARD_W * BOARD_H - 1, SEED, 1'b0);
		configure(BOARD_W, BOARD_H, MINES, 0, 1'b0);                  // Zero seed
		configure(BOARD_W, BOARD_H, MINES, SEED, 1'b1);
		check_all_hidden();
	end
	endtask

	task automatic test_moves();
		int x;
		int y;
	begin
		goto_cell(0, 0);
		move(CMD_LEFT);   // Wraps to the right edge
		move(CMD_UP);     // Wraps to the bottom row
		move(CMD_RIGHT);
		move(CMD_DOWN);
		repeat (4)
		begin
			x = int'($urandom % BOARD_W);
			y = int'($urandom % BOARD_H);
			goto_cell(x, y);
		end
	end
	endtask

	task automatic test_flags();
		bit found;
	begin
		found = 1'b0;
		for (int x = 0; x < BOARD_W; x++)
			for (int y = 0; y < BOARD_H; y++)
				if (!found && exp_tile[x][y] == TILE_HIDDEN)
				begin
					found = 1'b1;
					goto_cell(x, y);
				end
		flag_here();                // Hidden to flag
		reveal_at(cur_x, cur_y);    // Flag blocks the reveal
		flag_here();                // Back to hidden
	end
	endtask

	task automatic test_win();
		logic [TIMER_BITS-1:0] held;
	begin
		for (int x = 0; x < BOARD_W; x++)
			for (int y = 0; y < BOARD_H; y++)
				if (!mine[x][y] && exp_tile[x][y] == TILE_HIDDEN)
					reveal_at(x, y);
		expect_equal("status", status, ST_WON);
		held = timer;
		expect_equal("timer nonzero", timer != '0, 1);
		move(CMD_RIGHT);  // Ignored once won
		repeat (150) @(negedge clock);
		expect_equal("timer", timer, held);
	end
	endtask

	task automatic test_new_game();
	begin
		pulse_cmd(CMD_NEW_GAME);
		wait_not_busy();
		reset_model();
		expect_equal("timer", timer, 0);
		check_all_hidden();
	end
	endtask

	task automatic test_lose();
		int                    safe_left;
		bit                    found;
		logic [TIMER_BITS-1:0] held;
	begin
		reveal_at(int'($urandom % BOARD_W), int'($urandom % BOARD_H));
		safe_left = 2;
		for (int x = 0; x < BOARD_W; x++)
			for (int y = 0; y < BOARD_H; y++)
				if (safe_left > 0 && !mine[x][y] && exp_tile[x][y] == TILE_HIDDEN)
				begin
					reveal_at(x, y);
					safe_left--;
				end
		found = 1'b0;
		for (int x = 0; x < BOARD_W; x++)
			for (int y = 0; y < BOARD_H; y++)
				if (!found && mine[x][y])
				begin
					found = 1'b1;
					reveal_at(x, y);
				end
		expect_equal("status", status, ST_LOST);
		held = timer;
		move(CMD_LEFT);            // Everything but a new game is dropped
		flag_here();
		pulse_cmd(CMD_REVEAL);
		@(negedge clock);
		expect_equal("busy", busy, 0);  // Dropped reveal never starts
		check_cursor();
		repeat (120) @(negedge clock);
		expect_equal("timer", timer, held);
	end
	endtask

	initial
	begin
		clock       = 1'b0;
		resetn      = 1'b0;
		cfg_write   = 1'b0;
		cfg_board_x = '0;
		cfg_board_y = '0;
		cfg_mines   = '0;
		cfg_seed    = '0;
		cmd_valid   = 1'b0;
		cmd_op      = CMD_UP;
		errors      = 0;
		checks      = 0;
		cur_x       = 0;
		cur_y       = 0;
		first_done  = 1'b0;
		revealed    = 0;
		exp_status  = ST_SETUP;
		void'($urandom(32'h9788));
		repeat (10) @(posedge clock);
		resetn <= 1'b1;
		@(negedge clock);
		test_reset_config();
		test_moves();
		flag_here();        // Refused before the first reveal
		reveal_at(int'($urandom % BOARD_W), int'($urandom % BOARD_H));
		test_flags();
		test_win();
		test_new_game();
		test_lose();
		test_new_game();    // Out of the lost state
		finish_run();
	end

endmodule

// ==== files.f ====
hw/mine_pkg.sv
hw/game_config.sv
hw/game_control.sv
hw/board_walker.sv
hw/mine_field.sv
hw/tile_store.sv
hw/game_timer.sv
hw/minesweeper_top.sv
verif/minesweeper_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f files.f --top-module minesweeper_tb -o minesweeper_sim
out=$(./obj_dir/minesweeper_sim)
echo "$out"
if echo "$out" | grep -qx "test passed"; then
	exit 0
fi
exit 1
